// File: Makefile
# Verilator build and run for the integer execute unit

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       := exec_unit_tb
FILELIST  := exec_unit.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := CHECKS FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, judge the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: exec_unit.f
+incdir+tb
hw/exec_pkg.sv
hw/alu_core.sv
hw/mul_unit.sv
hw/result_merge.sv
hw/exec_unit.sv
tb/exec_unit_tb.sv

// File: hw/alu_core.sv
/*
 * ALU core
 * Single-cycle registered ALU for every operation except multiply,
 * with carry and signed overflow for the arithmetic group
 */

`timescale 1ns/10ps

module alu_core #(
    parameter int WIDTH = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  logic [WIDTH-1:0]  a,
    input  logic [WIDTH-1:0]  b,
    input  exec_pkg::alu_op_e op,
    output logic              alu_valid,
    output exec_pkg::alu_op_e alu_op,
    output logic [WIDTH-1:0]  alu_result,
    output logic              alu_carry,
    output logic              alu_overflow
);

    import exec_pkg::*;

    localparam int SHAMT_W = $clog2(WIDTH);
    localparam int MSB     = WIDTH - 1;

    logic [SHAMT_W-1:0] shamt;
    logic [WIDTH:0]     sum_ext;
    logic [WIDTH:0]     diff_ext;
    logic [WIDTH-1:0]   neg_b;
    logic               add_ovf;
    logic               sub_ovf;
    logic               neg_ovf;
    logic               slt_bit;
    logic [WIDTH-1:0]   result_c;
    logic               carry_c;
    logic               overflow_c;

    assign shamt = b[SHAMT_W-1:0];

    // Shared carry chains, one extra bit for carry out and borrow
    assign sum_ext  = {1'b0, a} + {1'b0, b};
    assign diff_ext = {1'b0, a} - {1'b0, b};
    assign neg_b    = '0 - b;

    // Signed overflow from operand and result signs
    assign add_ovf = (a[MSB] == b[MSB]) && (sum_ext[MSB] != a[MSB]);
    assign sub_ovf = (a[MSB] != b[MSB]) && (diff_ext[MSB] != a[MSB]);

    // Negating the most negative value wraps back to itself
    assign neg_ovf = (b == {1'b1, {(WIDTH-1){1'b0}}});

    // Signed less-than reuses the subtractor
    assign slt_bit = diff_ext[MSB] ^ sub_ovf;

    always_comb begin
        result_c   = '0;
        carry_c    = 1'b0;
        overflow_c = 1'b0;
        case (op)
            OP_ADD: begin
                result_c   = sum_ext[WIDTH-1:0];
                carry_c    = sum_ext[WIDTH];
                overflow_c = add_ovf;
            end
            OP_SUB: begin
                // Top bit of the difference is the unsigned borrow
                result_c   = diff_ext[WIDTH-1:0];
                carry_c    = diff_ext[WIDTH];
                overflow_c = sub_ovf;
            end
            OP_NEG_B: begin
                result_c   = neg_b;
                overflow_c = neg_ovf;
            end
            OP_AND:    result_c = a & b;
            OP_OR:     result_c = a | b;
            OP_NOT_A:  result_c = ~a;
            OP_XOR:    result_c = a ^ b;
            OP_SHL:    result_c = a << shamt;
            OP_SHR:    result_c = a >> shamt;
            OP_SHRA:   result_c = $signed(a) >>> shamt;
            OP_PASS_B: result_c = b;
            OP_SLT:    result_c = {{(WIDTH-1){1'b0}}, slt_bit};
            OP_SLTU:   result_c = {{(WIDTH-1){1'b0}}, diff_ext[WIDTH]};
            // Multiply and illegal codes leave everything at zero
            default: begin
                result_c   = '0;
                carry_c    = 1'b0;
                overflow_c = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            alu_op       <= op;
            alu_result   <= result_c;
            alu_carry    <= carry_c;
            alu_overflow <= overflow_c;
        end
    end

    // An accepted operation always carries a known opcode
    op_known_a: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> !$isunknown(op));

endmodule

// File: hw/exec_pkg.sv
/*
 * Execute unit package
 * Opcode encoding and the fixed pipeline latencies shared by the RTL
 */

package exec_pkg;

    // Operation codes, 4 bits wide
    // Codes 14 and 15 are illegal and give a zero result
    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_NEG_B  = 4'd2,
        OP_MUL    = 4'd3,
        OP_AND    = 4'd4,
        OP_OR     = 4'd5,
        OP_NOT_A  = 4'd6,
        OP_XOR    = 4'd7,
        OP_SHL    = 4'd8,
        OP_SHR    = 4'd9,
        OP_SHRA   = 4'd10,
        OP_PASS_B = 4'd11,
        OP_SLT    = 4'd12,
        OP_SLTU   = 4'd13
    } alu_op_e;

    // Cycles from in_valid to out_valid at the top level
    localparam int EXEC_LATENCY = 3;

    // Cycles through the multiplier
    localparam int MUL_LATENCY = 2;

endpackage

// File: hw/exec_unit.sv
/*
 * Integer execute unit
 * ALU and multiplier side by side, merged to a fixed three-cycle latency
 */

`timescale 1ns/10ps

module exec_unit #(
    parameter int WIDTH = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  logic [WIDTH-1:0]  a,
    input  logic [WIDTH-1:0]  b,
    input  exec_pkg::alu_op_e op,
    output logic              out_valid,
    output logic [WIDTH-1:0]  result,
    output logic              carry,
    output logic              overflow,
    output logic              zero
);

    import exec_pkg::*;

    logic             alu_valid;
    alu_op_e          alu_op;
    logic [WIDTH-1:0] alu_result;
    logic             alu_carry;
    logic             alu_overflow;

    logic             mul_valid;
    logic [WIDTH-1:0] mul_result;
    logic             mul_overflow;

    // Both units see every strobe
    alu_core #(
        .WIDTH(WIDTH)
    ) i_alu_core (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .a            (a),
        .b            (b),
        .op           (op),
        .alu_valid    (alu_valid),
        .alu_op       (alu_op),
        .alu_result   (alu_result),
        .alu_carry    (alu_carry),
        .alu_overflow (alu_overflow)
    );

    mul_unit #(
        .WIDTH(WIDTH)
    ) i_mul_unit (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .a            (a),
        .b            (b),
        .op           (op),
        .mul_valid    (mul_valid),
        .mul_result   (mul_result),
        .mul_overflow (mul_overflow)
    );

    result_merge #(
        .WIDTH(WIDTH)
    ) i_result_merge (
        .clk          (clk),
        .reset        (reset),
        .alu_valid    (alu_valid),
        .alu_carry    (alu_carry),
        .alu_overflow (alu_overflow),
        .alu_op       (alu_op),
        .alu_result   (alu_result),
        .mul_valid    (mul_valid),
        .mul_overflow (mul_overflow),
        .mul_result   (mul_result),
        .out_valid    (out_valid),
        .result       (result),
        .carry        (carry),
        .overflow     (overflow),
        .zero         (zero)
    );

endmodule

// File: hw/mul_unit.sv
/*
 * Signed multiplier
 * Two-stage pipeline producing the low product word and signed overflow
 */

`timescale 1ns/10ps

module mul_unit #(
    parameter int WIDTH = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  logic [WIDTH-1:0]  a,
    input  logic [WIDTH-1:0]  b,
    input  exec_pkg::alu_op_e op,
    output logic              mul_valid,
    output logic [WIDTH-1:0]  mul_result,
    output logic              mul_overflow
);

    import exec_pkg::*;

    logic [MUL_LATENCY-1:0]    valid_pipe;
    logic                      mul_q;
    logic signed [WIDTH-1:0]   a_q;
    logic signed [WIDTH-1:0]   b_q;
    logic signed [2*WIDTH-1:0] product;
    logic [WIDTH:0]            upper;

    // Valid follows every strobe, whatever the opcode
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
            mul_q      <= 1'b0;
        end else begin
            valid_pipe[0] <= in_valid;
            for (int i = 1; i < MUL_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
            mul_q <= in_valid && (op == OP_MUL);
        end
    end

    assign mul_valid = valid_pipe[MUL_LATENCY-1];

    // Stage one, operands held only for multiply
    always_ff @(posedge clk) begin
        if (in_valid && (op == OP_MUL)) begin
            a_q <= a;
            b_q <= b;
        end
    end

    assign product = a_q * b_q;

    // Fits WIDTH signed bits only if the upper half matches the sign bit
    assign upper = product[2*WIDTH-1:WIDTH-1];

    // Stage two
    always_ff @(posedge clk) begin
        if (mul_q) begin
            mul_result   <= product[WIDTH-1:0];
            mul_overflow <= !((&upper) || !(|upper));
        end
    end

    mul_valid_latency_a: assert property (@(posedge clk) disable iff (reset)
        (!$past(reset) && !$past(reset, 2)) |->
            (mul_valid == $past(in_valid, MUL_LATENCY)));

endmodule

// File: hw/result_merge.sv
/*
 * Result merge stage
 * Lines the ALU path up with the multiplier, selects the result,
 * forms the zero flag and registers the outputs
 */

`timescale 1ns/10ps

module result_merge #(
    parameter int WIDTH = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              alu_valid,
    input  logic              alu_carry,
    input  logic              alu_overflow,
    input  exec_pkg::alu_op_e alu_op,
    input  logic [WIDTH-1:0]  alu_result,
    input  logic              mul_valid,
    input  logic              mul_overflow,
    input  logic [WIDTH-1:0]  mul_result,
    output logic              out_valid,
    output logic [WIDTH-1:0]  result,
    output logic              carry,
    output logic              overflow,
    output logic              zero
);

    import exec_pkg::*;

    // ALU is one cycle, so it waits the rest of the multiplier latency
    localparam int ALU_DELAY = MUL_LATENCY - 1;

    logic [ALU_DELAY-1:0] valid_pipe;
    logic [ALU_DELAY-1:0] carry_pipe;
    logic [ALU_DELAY-1:0] ovf_pipe;
    alu_op_e              op_pipe     [ALU_DELAY];
    logic [WIDTH-1:0]     result_pipe [ALU_DELAY];

    logic                 valid_d;
    alu_op_e              op_d;
    logic [WIDTH-1:0]     sel_result;
    logic                 sel_carry;
    logic                 sel_overflow;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= alu_valid;
            for (int i = 1; i < ALU_DELAY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        op_pipe[0]     <= alu_op;
        result_pipe[0] <= alu_result;
        carry_pipe[0]  <= alu_carry;
        ovf_pipe[0]    <= alu_overflow;
        for (int i = 1; i < ALU_DELAY; i++) begin
            op_pipe[i]     <= op_pipe[i-1];
            result_pipe[i] <= result_pipe[i-1];
            carry_pipe[i]  <= carry_pipe[i-1];
            ovf_pipe[i]    <= ovf_pipe[i-1];
        end
    end

    assign valid_d = valid_pipe[ALU_DELAY-1];
    assign op_d    = op_pipe[ALU_DELAY-1];

    // Delayed opcode alone picks the source path
    always_comb begin
        if (op_d == OP_MUL) begin
            sel_result   = mul_result;
            sel_carry    = 1'b0;
            sel_overflow = mul_overflow;
        end else begin
            sel_result   = result_pipe[ALU_DELAY-1];
            sel_carry    = carry_pipe[ALU_DELAY-1];
            sel_overflow = ovf_pipe[ALU_DELAY-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            result    <= '0;
            carry     <= 1'b0;
            overflow  <= 1'b0;
            zero      <= 1'b0;
        end else begin
            out_valid <= valid_d;
            if (valid_d) begin
                result   <= sel_result;
                carry    <= sel_carry;
                overflow <= sel_overflow;
                zero     <= (sel_result == '0);
            end
        end
    end

    // Both paths must arrive on the same cycle
    paths_aligned_a: assert property (@(posedge clk) disable iff (reset)
        mul_valid == valid_d);

    // ALU strobe at t+1 comes out at t+EXEC_LATENCY
    out_latency_a: assert property (@(posedge clk) disable iff (reset)
        (!$past(reset) && !$past(reset, 2)) |->
            (out_valid == $past(alu_valid, EXEC_LATENCY - 1)));

    out_known_a: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !$isunknown({result, carry, overflow, zero}));

endmodule

// File: tb/exec_model.svh
/*
 * Reference model for the execute unit testbench
 * Expected result and flags per opcode, plus the Galois LFSR step
 */

`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Expected result, carry and overflow, worked out in wide integer arithmetic
function automatic void model_exec(input alu_op_e op, input logic [WIDTH-1:0] a,
                                   input logic [WIDTH-1:0] b,
                                   output logic [WIDTH-1:0] res,
                                   output logic carry, output logic overflow);
    longint ua;
    longint ub;
    longint sa;
    longint sb;
    longint full;
    longint smax;
    longint smin;
    longint umod;
    int     sh;
    ua   = longint'(a);
    ub   = longint'(b);
    sa   = longint'($signed(a));
    sb   = longint'($signed(b));
    umod = longint'(1) << WIDTH;
    smax = (longint'(1) << (WIDTH - 1)) - 1;
    smin = -smax - 1;
    sh   = int'(ub & ((longint'(1) << $clog2(WIDTH)) - 1));
    full     = 0;
    carry    = 1'b0;
    overflow = 1'b0;
    res      = '0;
    case (op)
        OP_ADD: begin
            full     = ua + ub;
            carry    = (full >= umod);
            overflow = ((sa + sb) > smax) || ((sa + sb) < smin);
            res      = full[WIDTH-1:0];
        end
        OP_SUB: begin
            full     = ua - ub;
            carry    = (ua < ub);
            overflow = ((sa - sb) > smax) || ((sa - sb) < smin);
            res      = full[WIDTH-1:0];
        end
        OP_NEG_B: begin
            full     = -sb;
            overflow = (full > smax);
            res      = full[WIDTH-1:0];
        end
        OP_MUL: begin
            full     = sa * sb;
            overflow = (full > smax) || (full < smin);
            res      = full[WIDTH-1:0];
        end
        OP_AND:    res = a & b;
        OP_OR:     res = a | b;
        OP_NOT_A:  res = ~a;
        OP_XOR:    res = a ^ b;
        OP_SHL: begin
            full = ua << sh;
            res  = full[WIDTH-1:0];
        end
        OP_SHR: begin
            full = ua >> sh;
            res  = full[WIDTH-1:0];
        end
        OP_SHRA: begin
            full = sa >>> sh;
            res  = full[WIDTH-1:0];
        end
        OP_PASS_B: res = b;
        OP_SLT:    res[0] = (sa < sb);
        OP_SLTU:   res[0] = (ua < ub);
        default:   res = '0;
    endcase
endfunction

// Right-shifting Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
endfunction

`endif

// File: tb/exec_unit_tb.sv
/*
 * Testbench for the integer execute unit
 * LFSR-driven operations checked in issue order against a reference model
 */

`timescale 1ns/10ps

module exec_unit_tb;

    import exec_pkg::*;

    localparam int WIDTH          = 8;
    localparam int CLK_HALF       = 50;
    localparam int DRIVE_DELAY    = 10;
    localparam int RESET_CYCLES   = 16;
    localparam int IDLE_CYCLES    = 6;
    localparam int NUM_OPS        = 600;
    localparam int MAX_GAP        = 3;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES
                                    + NUM_OPS * (MAX_GAP + 1) + 50;

    `include "exec_model.svh"

    typedef struct packed {
        alu_op_e          op;
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [WIDTH-1:0] res;
        logic             carry;
        logic             overflow;
        logic             zero;
        int               issue_cycle;
    } pending_t;

    logic             clk = 1'b0;
    logic             reset;
    logic             in_valid;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    alu_op_e          op;
    logic             out_valid;
    logic [WIDTH-1:0] result;
    logic             carry;
    logic             overflow;
    logic             zero;

    pending_t    pending_q[$];
    logic [31:0] lfsr_state   = 32'hf5b6d960;
    int          cycle        = 0;
    int          word_errors  = 0;
    int          flag_errors  = 0;
    int          other_errors = 0;
    logic        issued_any   = 1'b0;

    exec_unit #(
        .WIDTH(WIDTH)
    ) i_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .op        (op),
        .out_valid (out_valid),
        .result    (result),
        .carry     (carry),
        .overflow  (overflow),
        .zero      (zero)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // One LFSR step per bit, first bit taken ends up as the MSB
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // A quarter of the operands are 0, 1, most negative or all ones
    function automatic logic [WIDTH-1:0] draw_operand();
        logic [31:0] raw;
        raw = take_bits(2);
        if (raw == 32'd0) begin
            raw = take_bits(2);
            case (raw[1:0])
                2'd0:    return '0;
                2'd1:    return {{(WIDTH-1){1'b0}}, 1'b1};
                2'd2:    return {1'b1, {(WIDTH-1){1'b0}}};
                default: return '1;
            endcase
        end
        raw = take_bits(WIDTH);
        return raw[WIDTH-1:0];
    endfunction

    function automatic string op_label(input alu_op_e code);
        if (code > OP_SLTU) begin
            return "ILLEGAL";
        end
        return code.name();
    endfunction

    task automatic check_word(input string name, input logic [WIDTH-1:0] expected,
                              input logic [WIDTH-1:0] actual);
        if (actual !== expected) begin
            word_errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            flag_errors++;
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Drives one random operation, 4-bit draw reaches the illegal codes too
    task automatic issue_random();
        logic [31:0]      raw;
        logic [WIDTH-1:0] res_m;
        logic             carry_m;
        logic             ovf_m;
        pending_t         entry;
        raw      = take_bits(4);
        entry.op = alu_op_e'(raw[3:0]);
        entry.a  = draw_operand();
        entry.b  = draw_operand();
        model_exec(entry.op, entry.a, entry.b, res_m, carry_m, ovf_m);
        entry.res         = res_m;
        entry.carry       = carry_m;
        entry.overflow    = ovf_m;
        entry.zero        = (res_m == '0);
        entry.issue_cycle = cycle;
        in_valid = 1'b1;
        a        = entry.a;
        b        = entry.b;
        op       = entry.op;
        pending_q.push_back(entry);
        issued_any = 1'b1;
    endtask

    // Outputs are sampled mid-cycle
    always @(negedge clk) begin
        pending_t entry;
        string    tname;
        if (!reset && !issued_any) begin
            check_flag("idle after reset out_valid", 1'b0, out_valid);
            check_word("idle after reset result", '0, result);
            check_flag("idle after reset carry", 1'b0, carry);
            check_flag("idle after reset overflow", 1'b0, overflow);
            check_flag("idle after reset zero", 1'b0, zero);
        end else if (!reset && out_valid) begin
            if (pending_q.size() == 0) begin
                other_errors++;
                $display("out_valid at cycle %0d with no operation in flight", cycle);
            end else begin
                entry = pending_q.pop_front();
                tname = $sformatf("%s a=%h b=%h", op_label(entry.op), entry.a, entry.b);
                check_word({tname, " result"}, entry.res, result);
                check_flag({tname, " carry"}, entry.carry, carry);
                check_flag({tname, " overflow"}, entry.overflow, overflow);
                check_flag({tname, " zero"}, entry.zero, zero);
                if (cycle - entry.issue_cycle != EXEC_LATENCY) begin
                    other_errors++;
                    $display("ERROR %s latency: expected %0d, actual %0d", tname,
                             EXEC_LATENCY, cycle - entry.issue_cycle);
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("Timeout at cycle %0d with %0d operations still waiting for a result",
                 cycle, pending_q.size());
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] raw;
        int          gap;
        reset    = 1'b1;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        op       = OP_ADD;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        repeat (IDLE_CYCLES) @(posedge clk);
        #DRIVE_DELAY;

        // Mostly back-to-back, with an occasional gap of up to three cycles
        for (int n = 0; n < NUM_OPS; n++) begin
            raw = take_bits(2);
            gap = (raw == 32'd3) ? int'(take_bits(2)) : 0;
            in_valid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            issue_random();
            @(posedge clk);
            #DRIVE_DELAY;
        end
        in_valid = 1'b0;

        // Last result is due after the fixed latency, then a stray out_valid shows up
        repeat (EXEC_LATENCY + 2) @(posedge clk);
        if (pending_q.size() != 0) begin
            other_errors++;
            $display("%0d operations never produced a result", pending_q.size());
        end

        $display("Errors: %0d word, %0d flag, %0d other", word_errors, flag_errors,
                 other_errors);
        if (word_errors + flag_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
